/* compile.f */
+incdir+hw
hw/core_pkg.sv
hw/reset_sequencer.sv
hw/misc_settings.sv
hw/vita_timer.sv
hw/readback_mux.sv
hw/core_top.sv
testbench/core_checker.sv
testbench/tb_core.sv

/* hw/core_config.svh */
// Settings register map, field widths and reset values
// Compatibility number and readback slot count
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus

`define SET_ADDR_W 8
`define SET_DATA_W 32

// Register bases
`define SR_MISC   8'd0     // 7 regs
`define SR_TIME64 8'd10    // 2 regs
`define SR_DIVSW  8'd180   // 2 regs

// Offsets from SR_MISC
`define OFS_CLK_CTRL  8'd0
`define OFS_SER_CTRL  8'd1
`define OFS_ADC_CTRL  8'd2
`define OFS_LED_SW    8'd3
`define OFS_PHY_RST   8'd4
`define OFS_BLDR_DONE 8'd5
`define OFS_LED_SRC   8'd6

// Offsets from SR_TIME64 and SR_DIVSW
`define OFS_TIME_HI 8'd0
`define OFS_TIME_LO 8'd1
`define OFS_DIVSW1  8'd0
`define OFS_DIVSW2  8'd1

////////////////////////////////////////////////////////////////////////////
// Field widths and reset values

`define CLK_CTRL_W 5
`define SER_CTRL_W 4
`define ADC_CTRL_W 4
`define LED_W      8

`define LED_SRC_RESET 8'h1E   // 1 selects the hardware pattern

// Bump when the register map changes
`define COMPAT_MAJOR 16'd8
`define COMPAT_MINOR 16'd2

`define RB_WORDS 16

`endif

/* hw/core_pkg.sv */
// Shared types for the control core
// Settings bus word, packed control outputs, readback slots, boot states
package core_pkg;

`include "core_config.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus

   // One-cycle write strobe with address and data
   typedef struct packed {
      logic                   stb;
      logic [`SET_ADDR_W-1:0] addr;
      logic [`SET_DATA_W-1:0] data;
   } set_bus_t;

   ////////////////////////////////////////////////////////////////////////////
   // Control outputs

   typedef struct packed {
      // Clock generator
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      // SERDES
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      // ADC enables
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;   // Active low to the PHY
      // Diversity switches
      logic       div_sw1;
      logic       div_sw2;
   } ctrl_out_t;

   // Readback slots, unnamed ones read as zero
   typedef enum logic [$clog2(`RB_WORDS)-1:0] {
      RB_TIME_HI = 4'd10,
      RB_TIME_LO = 4'd11,
      RB_COMPAT  = 4'd12,
      RB_STATUS  = 4'd13,
      RB_PPS_HI  = 4'd14,
      RB_PPS_LO  = 4'd15
   } rb_word_e;

   typedef enum logic {
      BLDR_WAIT = 1'b0,
      BLDR_DONE = 1'b1
   } bldr_state_e;

endpackage

/* hw/core_top.sv */
// Control and status core top level
// Reset sequencer, setting registers, VITA timer and readback mux
`timescale 1ns/1ps

module core_top
   import core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   // Settings bus and readback
   input  set_bus_t   set_i,
   input  logic       rb_stb_i,
   input  rb_word_e   rb_addr_i,
   // Board status
   input  logic       pps_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       button_i,
   output logic [7:0] leds_o,
   output ctrl_out_t  ctrl_o,
   output logic [31:0] rb_data_o,
   output logic       rb_ack_o,
   output logic       boot_done_o
);

   logic        core_rst;    // Reset for everything after the sequencer
   logic        bldr_done;
   logic        good_sync;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   reset_sequencer u_reset_sequencer (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst),
      .boot_done_o (boot_done_o)
   );

   misc_settings u_misc_settings (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst),
      .set_i            (set_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .ctrl_o           (ctrl_o),
      .leds_o           (leds_o),
      .bldr_done_o      (bldr_done)
   );

   vita_timer u_vita_timer (
      .dsp_clk         (dsp_clk),
      .core_rst_i      (core_rst),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

   readback_mux u_readback_mux (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst),
      .rb_stb_i         (rb_stb_i),
      .rb_addr_i        (rb_addr_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .button_i         (button_i),
      .rb_data_o        (rb_data_o),
      .rb_ack_o         (rb_ack_o)
   );

endmodule

/* hw/misc_settings.sv */
// Miscellaneous setting registers and diversity switches
// LED mux between hardware status and software value
`timescale 1ns/1ps

module misc_settings
   import core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       core_rst_i,
   input  set_bus_t   set_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       good_sync_i,
   output ctrl_out_t  ctrl_o,
   output logic [7:0] leds_o,
   output logic       bldr_done_o
);

`include "core_config.svh"

   logic [`CLK_CTRL_W-1:0] clk_ctrl;
   logic [`SER_CTRL_W-1:0] ser_ctrl;
   logic [`ADC_CTRL_W-1:0] adc_ctrl;
   logic [`LED_W-1:0]      led_sw;    // Software LED value
   logic [`LED_W-1:0]      led_src;   // 1 = hardware, 0 = software
   logic [`LED_W-1:0]      led_hw;
   logic                   phy_rst;
   logic                   div_sw1;
   logic                   div_sw2;

   ////////////////////////////////////////////////////////////////////////////
   // Register decode

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         clk_ctrl    <= '0;
         ser_ctrl    <= '0;
         adc_ctrl    <= '0;
         led_sw      <= '0;
         led_src     <= `LED_SRC_RESET;
         phy_rst     <= 1'b0;
         bldr_done_o <= 1'b0;
         div_sw1     <= 1'b1;   // Switches come up on
         div_sw2     <= 1'b1;
      end else if (set_i.stb) begin
         case (set_i.addr)
            `SR_MISC + `OFS_CLK_CTRL:  clk_ctrl    <= set_i.data[`CLK_CTRL_W-1:0];
            `SR_MISC + `OFS_SER_CTRL:  ser_ctrl    <= set_i.data[`SER_CTRL_W-1:0];
            `SR_MISC + `OFS_ADC_CTRL:  adc_ctrl    <= set_i.data[`ADC_CTRL_W-1:0];
            `SR_MISC + `OFS_LED_SW:    led_sw      <= set_i.data[`LED_W-1:0];
            `SR_MISC + `OFS_PHY_RST:   phy_rst     <= set_i.data[0];
            `SR_MISC + `OFS_BLDR_DONE: bldr_done_o <= set_i.data[0];
            `SR_MISC + `OFS_LED_SRC:   led_src     <= set_i.data[`LED_W-1:0];
            `SR_DIVSW + `OFS_DIVSW1:   div_sw1     <= set_i.data[0];
            `SR_DIVSW + `OFS_DIVSW2:   div_sw2     <= set_i.data[0];
            default: ;   // Other blocks own the rest of the map
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control outputs

   always_comb begin
      {ctrl_o.clock_ready, ctrl_o.clk_en, ctrl_o.clk_sel} = clk_ctrl;
      {ctrl_o.ser_enable, ctrl_o.ser_prbsen,
       ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = ser_ctrl;
      {ctrl_o.adc_oe_a, ctrl_o.adc_on_a,
       ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_ctrl;
      ctrl_o.phy_reset_n = ~phy_rst;
      ctrl_o.div_sw1     = div_sw1;
      ctrl_o.div_sw2     = div_sw2;
   end

   ////////////////////////////////////////////////////////////////////////////
   // LEDs

   // Bit 2 clock status, bit 1 link with timing sync
   assign led_hw = {5'b0, clk_status_i, serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* hw/readback_mux.sv */
// Status readback mux with 16 word slots
// Registered word and one-cycle ack
`timescale 1ns/1ps

module readback_mux
   import core_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        core_rst_i,
   input  logic        rb_stb_i,
   input  rb_word_e    rb_addr_i,
   input  logic [63:0] vita_time_i,
   input  logic [63:0] vita_time_pps_i,
   input  logic        clk_status_i,
   input  logic        serdes_link_up_i,
   input  logic        button_i,
   output logic [31:0] rb_data_o,
   output logic        rb_ack_o
);

`include "core_config.svh"

   logic [31:0] status_word;
   logic [31:0] rb_word;

   // Button at 13, clock status at 11, link at 10
   assign status_word = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_comb begin
      case (rb_addr_i)
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = {`COMPAT_MAJOR, `COMPAT_MINOR};
         RB_STATUS:  rb_word = status_word;
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:    rb_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   // Word held until the next request
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_word;
      end
   end

   a_ack_follows_stb: assert property (@(posedge dsp_clk)
      rb_ack_o |-> $past(rb_stb_i));

endmodule

/* hw/reset_sequencer.sv */
// Bootloader reset sequencer
// Holds the core in reset after power-on, then gives one extra reset
`timescale 1ns/1ps

module reset_sequencer
   import core_pkg::*;
(
   input  logic dsp_clk,
   input  logic por_rst,
   input  logic bldr_done_i,   // Set by the bootloader
   output logic core_rst_o,
   output logic boot_done_o
);

   bldr_state_e state;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state      <= BLDR_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         case (state)
            BLDR_WAIT: begin
               core_rst_o <= bldr_done_i;   // One reset pulse on handoff
               if (bldr_done_i) begin
                  state <= BLDR_DONE;
               end
            end
            BLDR_DONE: begin
               core_rst_o <= 1'b0;   // Stay here until power-on reset
            end
            default: begin
               state <= BLDR_WAIT;
            end
         endcase
      end
   end

   assign boot_done_o = (state == BLDR_DONE);

   // The handoff reset lasts one cycle only
   a_single_rst: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (state == BLDR_DONE && core_rst_o) |=> !core_rst_o);

endmodule

/* hw/vita_timer.sv */
// 64-bit VITA time counter
// Two-word load from the settings bus and capture on rising PPS
`timescale 1ns/1ps

module vita_timer
   import core_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        core_rst_i,
   input  set_bus_t    set_i,
   input  logic        pps_i,
   output logic [63:0] vita_time_o,
   output logic [63:0] vita_time_pps_o,
   output logic        good_sync_o
);

`include "core_config.svh"

   logic [31:0] time_hi_hold;   // High word waits for the low write
   logic        time_hi_wr;
   logic        time_load;
   logic        pps_q;
   logic        pps_rise;

   assign time_hi_wr = set_i.stb && (set_i.addr == `SR_TIME64 + `OFS_TIME_HI);
   assign time_load  = set_i.stb && (set_i.addr == `SR_TIME64 + `OFS_TIME_LO);

   // Edge seen as the register goes low to high
   assign pps_rise = pps_i & ~pps_q;

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         time_hi_hold    <= '0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_q           <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         pps_q <= pps_i;

         if (time_hi_wr) begin
            time_hi_hold <= set_i.data;
         end

         if (time_load) begin
            vita_time_o <= {time_hi_hold, set_i.data};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end

         if (pps_rise) begin
            vita_time_pps_o <= vita_time_o;
         end

         // Sync lost on load, regained on the next pulse
         if (time_load) begin
            good_sync_o <= 1'b0;
         end else if (pps_rise) begin
            good_sync_o <= 1'b1;
         end
      end
   end

   // Free running between loads
   a_count_step: assert property (@(posedge dsp_clk)
      (!core_rst_i && !time_load) |=> (vita_time_o == $past(vita_time_o) + 64'd1));

endmodule

/* testbench/core_checker.sv */
// Testbench checker for the control core
// Compares DUT outputs with expected values and counts errors
`timescale 1ns/1ps

module core_checker
   import core_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        rb_stb_i,
   input  logic        rb_ack_i,
   input  logic [31:0] rb_data_i,
   input  logic        rb_check_i,     // Compare the word of this ack
   input  logic [31:0] exp_rb_i,
   input  logic        settle_chk_i,   // Compare ctrl, LEDs and boot flag
   input  ctrl_out_t   ctrl_i,
   input  ctrl_out_t   exp_ctrl_i,
   input  logic [7:0]  leds_i,
   input  logic [7:0]  exp_leds_i,
   input  logic        boot_done_i,
   input  logic        exp_boot_done_i,
   output int          error_count_o
);

   int   checks = 0;
   int   value_errors = 0;
   int   other_errors = 0;
   logic stb_q = 1'b0;   // Request seen at the last edge

   assign error_count_o = value_errors + other_errors;

   task automatic compare_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
      checks++;
      if (act_v !== exp_v) begin
         value_errors++;
         $display("FAIL %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      checks++;
      if (!ok) begin
         other_errors++;
         $display("ERROR %s at %0t", what, $time);
      end
   endtask

   task automatic print_summary();
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sampled at the rising edge, where every DUT output is stable

   always @(posedge dsp_clk) begin
      if (por_rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= rb_stb_i;
         if (stb_q && !rb_ack_i) begin
            check_true(1'b0, "readback request got no ack in the next cycle");
         end
         if (rb_ack_i && !stb_q) begin
            check_true(1'b0, "ack arrived without a readback request");
         end
         if (rb_ack_i && rb_check_i) begin
            compare_value("rb_data_o", exp_rb_i, rb_data_i);
         end
         if (settle_chk_i) begin
            compare_value("ctrl_o", exp_ctrl_i, ctrl_i);
            compare_value("leds_o", exp_leds_i, leds_i);
            compare_value("boot_done_o", exp_boot_done_i, boot_done_i);
         end
      end
   end

endmodule

/* testbench/tb_core.sv */
// Testbench for the control core
// Clock, reset, stimulus, reference model and watchdog
`timescale 1ns/1ps

module tb_core
   import core_pkg::*;
();

`include "core_config.svh"

   localparam int NUM_TRANS = 90;                        // Bus transactions, rounded up
   localparam int WATCHDOG_CYCLES = NUM_TRANS * 20 + 200;

   logic        dsp_clk = 1'b0;
   logic        por_rst;
   set_bus_t    set_bus;
   logic        rb_stb;
   rb_word_e    rb_addr;
   logic        pps;
   logic        clk_status;
   logic        link_up;
   logic        button;
   logic [7:0]  leds;
   ctrl_out_t   ctrl;
   logic [31:0] rb_data;
   logic        rb_ack;
   logic        boot_done;

   // Expected values and checker controls
   ctrl_out_t   exp_ctrl;
   logic [7:0]  exp_leds;
   logic [31:0] exp_rb;
   logic        exp_boot_done;
   logic        rb_check;
   logic        settle_chk;
   int          error_count;
   int          seed = 26668;
   int          cycle = 0;

   // Model of the setting registers
   logic [4:0]  m_clk;
   logic [3:0]  m_ser;
   logic [3:0]  m_adc;
   logic [7:0]  m_led_sw;
   logic [7:0]  m_led_src;
   logic        m_phy;
   logic        m_div1;
   logic        m_div2;
   logic        m_sync;

   always #50 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) begin
      cycle <= cycle + 1;
   end

   core_top dut (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_i            (set_bus),
      .rb_stb_i         (rb_stb),
      .rb_addr_i        (rb_addr),
      .pps_i            (pps),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (link_up),
      .button_i         (button),
      .leds_o           (leds),
      .ctrl_o           (ctrl),
      .rb_data_o        (rb_data),
      .rb_ack_o         (rb_ack),
      .boot_done_o      (boot_done)
   );

   core_checker chk (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_stb_i        (rb_stb),
      .rb_ack_i        (rb_ack),
      .rb_data_i       (rb_data),
      .rb_check_i      (rb_check),
      .exp_rb_i        (exp_rb),
      .settle_chk_i    (settle_chk),
      .ctrl_i          (ctrl),
      .exp_ctrl_i      (exp_ctrl),
      .leds_i          (leds),
      .exp_leds_i      (exp_leds),
      .boot_done_i     (boot_done),
      .exp_boot_done_i (exp_boot_done),
      .error_count_o   (error_count)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model

   function automatic ctrl_out_t ref_ctrl(input logic [4:0] clk, input logic [3:0] ser,
                                          input logic [3:0] adc, input logic phy,
                                          input logic sw1, input logic sw2);
      ctrl_out_t c;
      c.clock_ready = clk[4];
      c.clk_en      = clk[3:2];
      c.clk_sel     = clk[1:0];
      c.ser_enable  = ser[3];
      c.ser_prbsen  = ser[2];
      c.ser_loopen  = ser[1];
      c.ser_rx_en   = ser[0];
      c.adc_oe_a    = adc[3];
      c.adc_on_a    = adc[2];
      c.adc_oe_b    = adc[1];
      c.adc_on_b    = adc[0];
      c.phy_reset_n = !phy;     // PHY reset bit is active high
      c.div_sw1     = sw1;
      c.div_sw2     = sw2;
      return c;
   endfunction

   // Mask bit 1 picks the hardware pattern
   function automatic logic [7:0] ref_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input logic clk_st, input logic link,
                                           input logic sync);
      logic [7:0] hw;
      logic [7:0] led;
      hw    = 8'h00;
      hw[2] = clk_st;
      hw[1] = link && sync;
      for (int b = 0; b < 8; b++) begin
         led[b] = src[b] ? hw[b] : sw[b];
      end
      return led;
   endfunction

   function automatic logic [31:0] ref_status(input logic btn, input logic clk_st,
                                              input logic link);
      logic [31:0] w;
      w     = 32'h0;
      w[13] = btn;
      w[11] = clk_st;
      w[10] = link;
      return w;
   endfunction

   assign exp_ctrl = ref_ctrl(m_clk, m_ser, m_adc, m_phy, m_div1, m_div2);
   assign exp_leds = ref_leds(m_led_src, m_led_sw, clk_status, link_up, m_sync);

   task automatic reset_model();
      m_clk     = '0;
      m_ser     = '0;
      m_adc     = '0;
      m_led_sw  = '0;
      m_led_src = `LED_SRC_RESET;
      m_phy     = 1'b0;
      m_div1    = 1'b1;
      m_div2    = 1'b1;
      m_sync    = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks, all entered and left on a falling edge

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge dsp_clk);
      set_bus.stb = 1'b0;
      case (addr)
         `SR_MISC + 8'd0:   m_clk     = data[4:0];
         `SR_MISC + 8'd1:   m_ser     = data[3:0];
         `SR_MISC + 8'd2:   m_adc     = data[3:0];
         `SR_MISC + 8'd3:   m_led_sw  = data[7:0];
         `SR_MISC + 8'd4:   m_phy     = data[0];
         `SR_MISC + 8'd6:   m_led_src = data[7:0];
         `SR_TIME64 + 8'd1: m_sync    = 1'b0;   // Load drops sync
         `SR_DIVSW + 8'd0:  m_div1    = data[0];
         `SR_DIVSW + 8'd1:  m_div2    = data[0];
         default: ;
      endcase
   endtask

   task automatic check_settled();
      @(negedge dsp_clk);
      settle_chk = 1'b1;
      @(negedge dsp_clk);
      settle_chk = 1'b0;
   endtask

   task automatic read_word(input rb_word_e addr, input logic check, input logic [31:0] exp_v,
                            output logic [31:0] data);
      int wait_cnt;
      rb_stb   = 1'b1;
      rb_addr  = addr;
      rb_check = check;
      exp_rb   = exp_v;
      @(negedge dsp_clk);
      rb_stb   = 1'b0;
      wait_cnt = 0;
      while (!rb_ack && wait_cnt < 4) begin
         @(negedge dsp_clk);
         wait_cnt++;
      end
      data = rb_data;
      @(negedge dsp_clk);   // Checker sees the ack here
      rb_check = 1'b0;
   endtask

   task automatic random_writes();
      write_reg(`SR_MISC + 8'd0, $random(seed));
      write_reg(`SR_MISC + 8'd1, $random(seed));
      write_reg(`SR_MISC + 8'd2, $random(seed));
      write_reg(`SR_MISC + 8'd3, $random(seed));
      write_reg(`SR_MISC + 8'd4, $random(seed));
      write_reg(`SR_MISC + 8'd6, $random(seed));
      write_reg(`SR_DIVSW + 8'd0, $random(seed));
      write_reg(`SR_DIVSW + 8'd1, $random(seed));
      check_settled();
   endtask

   task automatic led_hw_sweep();
      write_reg(`SR_MISC + 8'd6, $random(seed) | 32'h6);
      for (int i = 0; i < 4; i++) begin
         clk_status = i[0];
         link_up    = i[1];
         check_settled();
      end
   endtask

   task automatic pulse_pps();
      pps = 1'b1;
      repeat (3) @(negedge dsp_clk);
      pps = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Watchdog

   initial begin
      #(WATCHDOG_CYCLES * 100);
      $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Tests

   initial begin
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] word;
      logic [63:0] load_val;
      logic [63:0] pps1;
      logic [63:0] pps2;
      int          gap;
      int          c0;
      por_rst       = 1'b1;
      set_bus       = '0;
      rb_stb        = 1'b0;
      rb_addr       = RB_TIME_HI;
      rb_check      = 1'b0;
      exp_rb        = '0;
      settle_chk    = 1'b0;
      exp_boot_done = 1'b0;
      pps           = 1'b0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      button        = 1'b0;
      reset_model();
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
      repeat (4) @(negedge dsp_clk);

      check_settled();                 // Reset values
      repeat (4) random_writes();
      led_hw_sweep();                  // Sync still low

      read_word(RB_COMPAT, 1'b1, 32'h0008_0002, word);
      for (int i = 0; i < 8; i++) begin
         {button, clk_status, link_up} = i[2:0];
         read_word(RB_STATUS, 1'b1, ref_status(button, clk_status, link_up), word);
      end
      for (int s = 0; s < 10; s++) begin
         read_word(rb_word_e'(s[3:0]), 1'b1, 32'h0, word);
      end

      // Time load, then two PPS edges gap cycles apart
      hi       = $random(seed) & 32'h7FFF_FFFF;   // Far from counter wrap
      lo       = $random(seed);
      load_val = {hi, lo};
      write_reg(`SR_TIME64 + 8'd0, hi);
      write_reg(`SR_TIME64 + 8'd1, lo);
      link_up = 1'b1;
      check_settled();
      gap = 24 + ($random(seed) & 15);
      c0  = cycle;
      pulse_pps();
      m_sync = 1'b1;
      read_word(RB_PPS_HI, 1'b0, 32'h0, hi);
      read_word(RB_PPS_LO, 1'b0, 32'h0, lo);
      pps1 = {hi, lo};
      check_settled();
      while (cycle < c0 + gap) begin
         @(negedge dsp_clk);
      end
      pulse_pps();
      read_word(RB_PPS_HI, 1'b0, 32'h0, hi);
      read_word(RB_PPS_LO, 1'b0, 32'h0, lo);
      pps2 = {hi, lo};
      chk.compare_value("pps_delta", gap, pps2 - pps1);
      chk.check_true(pps1 >= load_val, "first PPS time is below the loaded time");
      led_hw_sweep();                  // Sync now high

      // Bootloader handoff resets the core once
      write_reg(`SR_MISC + 8'd5, 32'h1);
      repeat (4) @(negedge dsp_clk);
      reset_model();
      exp_boot_done = 1'b1;
      check_settled();
      read_word(RB_TIME_HI, 1'b1, 32'h0, word);
      random_writes();
      write_reg(`SR_MISC + 8'd5, 32'h1);   // Values above must survive
      repeat (6) @(negedge dsp_clk);
      check_settled();

      chk.print_summary();
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
